/* Makefile */
# Verilator build and run for the 16-bit ALU testbench.

VERILATOR   ?= verilator
TOP         ?= alu_tb
FILELIST    ?= filelist.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
TIMESCALE   ?= 1ns/1ps
VFLAGS      ?= --binary --timing --assert --timescale $(TIMESCALE)
ERROR_LIMIT ?= 100
RUN_FLAGS   ?= +verilator+error+limit+$(ERROR_LIMIT)
FAIL_MSG    ?= sim failed
PASS_MSG    ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/alu_defs.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: no verdict in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_slice.sv
verilog/carry_lookahead.sv
verilog/alu_16bit.sv
verilog/alu_top.sv
test/clock_gen.sv
test/alu_props.sv
test/alu_checker.sv
test/alu_tb.sv

/* test/alu_checker.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_checker (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid,
    input  alu_pkg::word_t d1,
    input  alu_pkg::word_t d2,
    input  logic           carry_in,
    input  logic           carry_disable,
    input  alu_pkg::cmd_t  cmd,
    input  logic           out_valid,
    input  alu_pkg::word_t res,
    input  logic           carry_out,
    output int unsigned    mismatches,
    output int unsigned    unexpected,
    output int unsigned    pending
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`ALU_WIDTH:0] exp_q[$];  // carry_out in the top bit, res below it.
    int unsigned         pushed;
    int unsigned         popped;

    assign pending = pushed - popped;

    // Expected {carry_out, res} of one operation.
    function automatic logic [`ALU_WIDTH:0] expected_result(
        input alu_pkg::word_t a,
        input alu_pkg::word_t b,
        input logic           ci,
        input logic           cd,
        input alu_pkg::cmd_t  c
    );
        logic [`ALU_WIDTH:0]     r;
        logic [`ALU_SLICE_W-1:0] nib;
        r = '0;
        case (c)
            `CMD_ADD: begin
                if (cd) begin
                    // each nibble wraps on its own, only the lowest sees carry_in.
                    for (int k = 0; k < `ALU_SLICES; k++) begin
                        nib = a[k*`ALU_SLICE_W +: `ALU_SLICE_W]
                            + b[k*`ALU_SLICE_W +: `ALU_SLICE_W];
                        if (k == 0) begin
                            nib = nib + {3'b000, ci};
                        end
                        r[k*`ALU_SLICE_W +: `ALU_SLICE_W] = nib;
                    end
                end else begin
                    r = {1'b0, a} + {1'b0, b} + {{`ALU_WIDTH{1'b0}}, ci};
                end
            end
            `CMD_XOR: r = {1'b0, a ^ b};
            `CMD_AND: r = {1'b0, a & b};
            `CMD_OR: begin
                if (cd) begin
                    r = {1'b0, ci, b[`ALU_WIDTH-1:1]};  // right shift, carry_in on top.
                end else begin
                    r = {1'b0, a | b};
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    // Inputs were driven on the falling edge, so they are settled here.
    always @(posedge clk) begin
        if (arst_n && in_valid) begin
            exp_q.push_back(expected_result(d1, d2, carry_in, carry_disable, cmd));
            pushed++;
        end
    end

    // Outputs are compared mid cycle, while the stage two registers hold still.
    always @(negedge clk) begin : compare_blk
        logic [`ALU_WIDTH:0] want;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                unexpected++;
                $display("unexpected result at %0d ns: out_valid high with no input waiting",
                         $time);
            end else begin
                want = exp_q.pop_front();
                popped++;
                if ({carry_out, res} !== want) begin
                    mismatches++;
                    $display("Fail at %0d ns: res %h carry_out %b, expected res %h carry_out %b",
                             $time, res, carry_out, want[`ALU_WIDTH-1:0], want[`ALU_WIDTH]);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/alu_props.sv */
`default_nettype none

module alu_props (
    input logic           clk,
    input logic           arst_n,
    input logic           in_valid,
    input logic           s1_valid,
    input logic           out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned assert_errors;  // read by the testbench at the end of the run.

    stage_one_a: assert property (@(posedge clk) disable iff (!arst_n)
        s1_valid == $past(in_valid))
        else begin
            assert_errors++;
            $error("stage one valid does not follow in_valid by one edge");
        end

    // One pulse per accepted input, two edges later, for back to back inputs too.
    latency_a: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else begin
            assert_errors++;
            $error("out_valid is not in_valid delayed by two edges");
        end

    reset_quiet_a: assert property (@(posedge clk)
        !arst_n |-> (!out_valid && !s1_valid))
        else begin
            assert_errors++;
            $error("valid bits are not cleared while reset is asserted");
        end

endmodule

`default_nettype wire

/* test/alu_tb.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VECTORS  = 2000;  // one vector per clock cycle.
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = NUM_VECTORS + RESET_CYCLES + 100;

    logic           clk;
    logic           arst_n;
    logic           in_valid;
    alu_pkg::word_t d1;
    alu_pkg::word_t d2;
    logic           carry_in;
    logic           carry_disable;
    alu_pkg::cmd_t  cmd;
    logic           out_valid;
    alu_pkg::word_t res;
    logic           carry_out;

    int unsigned    mismatches;
    int unsigned    unexpected;
    int unsigned    pending;
    int unsigned    cycles;
    logic [15:0]    lfsr;

    clock_gen #(.HALF_PERIOD(50), .RESET_CYCLES(RESET_CYCLES)) clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    alu_top dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .d1            (d1),
        .d2            (d2),
        .carry_in      (carry_in),
        .carry_disable (carry_disable),
        .cmd           (cmd),
        .out_valid     (out_valid),
        .res           (res),
        .carry_out     (carry_out)
    );

    alu_checker compare_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .d1            (d1),
        .d2            (d2),
        .carry_in      (carry_in),
        .carry_disable (carry_disable),
        .cmd           (cmd),
        .out_valid     (out_valid),
        .res           (res),
        .carry_out     (carry_out),
        .mismatches    (mismatches),
        .unexpected    (unexpected),
        .pending       (pending)
    );

    bind alu_top alu_props props_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .s1_valid  (s1_valid),
        .out_valid (out_valid)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the lsb.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int count, output alu_pkg::word_t value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[`ALU_WIDTH-2:0], lfsr[0]};
        end
    endtask

    task automatic drive_vector(input int n);
        alu_pkg::word_t r;
        if (n % 50 == 0) begin
            // all ones plus carry_in sends a carry through every slice.
            in_valid      = 1'b1;
            d1            = '1;
            d2            = '1;
            carry_in      = 1'b1;
            carry_disable = 1'b0;
            cmd           = `CMD_ADD;
        end else begin
            draw_bits(2, r);
            in_valid = (r[1:0] != 2'b00);  // high three times out of four.
            draw_bits(`ALU_WIDTH, r);
            d1 = r;
            draw_bits(`ALU_WIDTH, r);
            d2 = r;
            draw_bits(1, r);
            carry_in = r[0];
            draw_bits(1, r);
            carry_disable = r[0];
            draw_bits(2, r);
            cmd = r[1:0];
        end
    endtask

    task automatic close_run(input bit timed_out);
        int total;
        total = mismatches + unexpected + pending + dut_i.props_i.assert_errors;
        if (timed_out) begin
            total++;
            $display("timeout: run stopped after %0d cycles", cycles);
        end
        $display("errors: %0d mismatched, %0d unexpected, %0d missing, %0d assertion failures",
                 mismatches, unexpected, pending, dut_i.props_i.assert_errors);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        in_valid      = 1'b0;
        d1            = '0;
        d2            = '0;
        carry_in      = 1'b0;
        carry_disable = 1'b0;
        cmd           = `CMD_ADD;
        lfsr          = 16'd34;
        @(posedge arst_n);
        @(posedge clk);
        for (int n = 1; n <= NUM_VECTORS; n++) begin
            @(negedge clk);
            drive_vector(n);
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);  // room for a stray pulse to show up.
        close_run(1'b0);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            close_run(1'b1);
        end
    end

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 50,  // half of the 100 ns clock period.
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // The release time is a falling edge, half a cycle away from any flop update.
    initial begin
        arst_n = 1'b0;
        #(2 * HALF_PERIOD * RESET_CYCLES) arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/alu_16bit.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_16bit (
    input  alu_pkg::word_t d1,
    input  alu_pkg::word_t d2,
    input  logic           carry_in,
    input  logic           carry_disable,
    input  alu_pkg::cmd_t  cmd,
    output alu_pkg::word_t res,
    output logic           carry_out
);

    alu_pkg::group_t gen;
    alu_pkg::group_t prop;
    alu_pkg::group_t carry;        // carry into each slice.
    alu_pkg::group_t shift_chain;  // bit shifted into the msb of each slice.

    assign carry[0] = carry_in;

    for (genvar k = 0; k < `ALU_SLICES; k++) begin : g_slice
        alu_pkg::nibble_t d1_nib;
        alu_pkg::nibble_t d2_nib;

        assign d1_nib = d1[k*`ALU_SLICE_W +: `ALU_SLICE_W];
        assign d2_nib = d2[k*`ALU_SLICE_W +: `ALU_SLICE_W];

        // The top slice takes carry_in, the others the lsb of the slice above.
        if (k == `ALU_SLICES-1) begin : g_top
            assign shift_chain[k] = carry_in;
        end else begin : g_inner
            assign shift_chain[k] = d2[(k+1)*`ALU_SLICE_W];
        end

        alu_slice slice_i (
            .d1            (d1_nib),
            .d2            (d2_nib),
            .carry         (carry[k]),
            .shift_in      (shift_chain[k]),
            .carry_disable (carry_disable),
            .cmd           (cmd),
            .res           (res[k*`ALU_SLICE_W +: `ALU_SLICE_W]),
            .gen           (gen[k]),
            .prop          (prop[k])
        );
    end

    carry_lookahead cla_i (
        .carry_in  (carry_in),
        .gen       (gen),
        .prop      (prop),
        .carry     (carry[`ALU_SLICES-1:1]),
        .carry_out (carry_out)
    );

endmodule

`default_nettype wire

/* verilog/alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Datapath geometry.
`define ALU_WIDTH   16
`define ALU_SLICE_W 4
`define ALU_SLICES  4

// Command encodings carried on cmd.
// With carry_disable set, ADD splits into nibble adds and OR becomes
// a one bit right shift of d2.
`define CMD_ADD 2'b00
`define CMD_XOR 2'b01
`define CMD_AND 2'b10
`define CMD_OR  2'b11

`endif

/* verilog/alu_pkg.sv */
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

    // full width operand or result.
    typedef logic [`ALU_WIDTH-1:0] word_t;

    // operand or result of a single slice.
    typedef logic [`ALU_SLICE_W-1:0] nibble_t;

    typedef logic [1:0] cmd_t;  // operation select.

    // one bit per slice for generate, propagate and carries.
    typedef logic [`ALU_SLICES-1:0] group_t;

endpackage

`default_nettype wire

/* verilog/alu_slice.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_slice (
    input  alu_pkg::nibble_t d1,
    input  alu_pkg::nibble_t d2,
    input  logic             carry,          // carry into bit 0 of the adder.
    input  logic             shift_in,       // bit entering the msb on a right shift.
    input  logic             carry_disable,
    input  alu_pkg::cmd_t    cmd,
    output alu_pkg::nibble_t res,
    output logic             gen,
    output logic             prop
);

    alu_pkg::nibble_t     bit_gen;
    alu_pkg::nibble_t     bit_prop;
    alu_pkg::nibble_t     ripple;
    alu_pkg::nibble_t     sum;
    logic                 grp_gen;
    logic                 grp_prop;
    logic                 chained_add;
    logic                 shift_op;

    assign bit_gen  = d1 & d2;
    assign bit_prop = d1 ^ d2;

    // Ripple carry inside the slice.
    always_comb begin
        ripple[0] = carry;
        for (int i = 0; i < `ALU_SLICE_W-1; i++) begin
            ripple[i+1] = bit_gen[i] | (bit_prop[i] & ripple[i]);
        end
    end

    assign sum = bit_prop ^ ripple;

    // Group generate is the slice carry out with a zero carry in.
    always_comb begin
        grp_gen = 1'b0;
        for (int i = 0; i < `ALU_SLICE_W; i++) begin
            grp_gen = bit_gen[i] | (bit_prop[i] & grp_gen);
        end
    end

    assign grp_prop = &bit_prop;  // a carry passes only if every bit propagates.

    assign chained_add = (cmd == `CMD_ADD) && !carry_disable;
    assign shift_op    = (cmd == `CMD_OR) && carry_disable;

    // Outside a chained add the lookahead must see no carry activity,
    // so split adds and logic ops leave the upper slices with carry 0.
    assign gen  = chained_add & grp_gen;
    assign prop = chained_add & grp_prop;

    always_comb begin
        case (cmd)
            `CMD_ADD: res = sum;
            `CMD_XOR: res = d1 ^ d2;
            `CMD_AND: res = d1 & d2;
            `CMD_OR: begin
                if (shift_op) begin
                    res = {shift_in, d2[`ALU_SLICE_W-1:1]};  // neighbour's lsb enters bit 3.
                end else begin
                    res = d1 | d2;
                end
            end
            default:  res = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu_top.sv */
`default_nettype none

module alu_top (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid,
    input  alu_pkg::word_t d1,
    input  alu_pkg::word_t d2,
    input  logic           carry_in,
    input  logic           carry_disable,
    input  alu_pkg::cmd_t  cmd,
    output logic           out_valid,
    output alu_pkg::word_t res,
    output logic           carry_out
);

    logic           s1_valid;
    alu_pkg::word_t s1_d1;
    alu_pkg::word_t s1_d2;
    logic           s1_carry_in;
    logic           s1_carry_disable;
    alu_pkg::cmd_t  s1_cmd;

    alu_pkg::word_t alu_res;
    logic           alu_carry_out;

    // Stage one captures the operands of each accepted input.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid         <= 1'b0;
            s1_d1            <= '0;
            s1_d2            <= '0;
            s1_carry_in      <= 1'b0;
            s1_carry_disable <= 1'b0;
            s1_cmd           <= '0;
        end else begin
            s1_valid <= in_valid;  // follows the strobe every cycle.
            if (in_valid) begin
                s1_d1            <= d1;
                s1_d2            <= d2;
                s1_carry_in      <= carry_in;
                s1_carry_disable <= carry_disable;
                s1_cmd           <= cmd;
            end
        end
    end

    alu_16bit alu_i (
        .d1            (s1_d1),
        .d2            (s1_d2),
        .carry_in      (s1_carry_in),
        .carry_disable (s1_carry_disable),
        .cmd           (s1_cmd),
        .res           (alu_res),
        .carry_out     (alu_carry_out)
    );

    // Stage two holds the result for the cycle that out_valid is high.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            res       <= '0;
            carry_out <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            if (s1_valid) begin
                res       <= alu_res;
                carry_out <= alu_carry_out;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/carry_lookahead.sv */
`default_nettype none

`include "alu_defs.svh"

module carry_lookahead (
    input  logic                   carry_in,
    input  alu_pkg::group_t        gen,
    input  alu_pkg::group_t        prop,
    output logic [`ALU_SLICES-1:1] carry,      // carries into slices 1 to 3.
    output logic                   carry_out
);

    // Every output is a flat sum of products, so no carry waits on another.
    assign carry[1] = gen[0]
                    | (prop[0] & carry_in);

    assign carry[2] = gen[1]
                    | (prop[1] & gen[0])
                    | (prop[1] & prop[0] & carry_in);

    assign carry[3] = gen[2]
                    | (prop[2] & gen[1])
                    | (prop[2] & prop[1] & gen[0])
                    | (prop[2] & prop[1] & prop[0] & carry_in);

    // The 17th bit of a chained add.
    assign carry_out = gen[3]
                     | (prop[3] & gen[2])
                     | (prop[3] & prop[2] & gen[1])
                     | (prop[3] & prop[2] & prop[1] & gen[0])
                     | (prop[3] & prop[2] & prop[1] & prop[0] & carry_in);

endmodule

`default_nettype wire
